// ==== source/psram_settings.svh ====
`ifndef PSRAM_SETTINGS_SVH
`define PSRAM_SETTINGS_SVH

// sys_clk cycles per psram clock, multiple of 4
`define PSRAM_CLK_DIV 4

// power-up wait in sys_clk cycles, shortened for simulation
`define PSRAM_INIT_CYCLES 200

// ce high time between transactions, sys_clk cycles
`define PSRAM_CPH_CYCLES 6

// access latency in psram clocks (3 to 7) and its mode register code
`define PSRAM_LATENCY 5
`define PSRAM_LATENCY_CODE 3'b010

// MR8 fields
`define PSRAM_X16 1'b1
`define PSRAM_HYBRID_WRAP 1'b0
`define PSRAM_BL_CODE 2'b01

// largest beat count of one burst
`define PSRAM_MAX_BURST 64

`endif

// ==== source/psram_pkg.sv ====
package psram_pkg;

    // one user transaction
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [11:0] burst_len;
    } psram_req_t;

    // one write beat, mask bit set means byte is skipped
    typedef struct packed {
        logic [15:0] data;
        logic [1:0]  mask;
    } psram_beat_t;

    typedef enum logic [3:0] {
        POWER_UP,
        RESET_CMD,
        RESET_WAIT,
        MR_WRITE,
        READY,
        COMMAND,
        ADDRESS,
        LATENCY,
        WRITE,
        READ,
        DONE,
        RECOVER
    } psram_state_e;

    // what the encoder puts on the bus next
    typedef struct packed {
        psram_state_e state;
        logic [1:0]   mr_index;
        logic [1:0]   beat_idx;
        psram_req_t   req;
    } bus_phase_t;

    typedef struct packed {
        logic [15:0] dq;
        logic [1:0]  dm;
    } psram_pad_t;

endpackage

// ==== source/psram_clk_gen.sv ====
`timescale 1ns/100ps
`include "psram_settings.svh"

module psram_clk_gen (
    input  logic sys_clk,
    input  logic sys_rst,
    input  logic clk_run,
    output logic psram_clk,
    output logic div_last,
    output logic mend
);
    localparam int DIV = `PSRAM_CLK_DIV;
    localparam int CW  = $clog2(DIV);

    logic [CW-1:0] div_cnt;

    // divide counter restarts from zero each time the clock is enabled
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            div_cnt <= '0;
        end else if (!clk_run || div_cnt == CW'(DIV - 1)) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign div_last = clk_run && (div_cnt == CW'(DIV - 1));

    // low half first, then high half
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            psram_clk <= 1'b0;
        end else if (!clk_run) begin
            psram_clk <= 1'b0;
        end else begin
            psram_clk <= (div_cnt >= CW'(DIV / 2));
        end
    end

    // data change points, centered between the clock edges
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            mend <= 1'b0;
        end else begin
            mend <= clk_run && (div_cnt == CW'(DIV / 4 - 1) || div_cnt == CW'(3 * DIV / 4 - 1));
        end
    end

    a_clk_stops: assert property (@(posedge sys_clk) disable iff (!sys_rst)
        !$past(clk_run) |-> !psram_clk);

endmodule

// ==== source/psram_sequencer.sv ====
`timescale 1ns/100ps
`include "psram_settings.svh"

module psram_sequencer (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    input  logic                  req_valid,
    input  psram_pkg::psram_req_t req,
    input  logic                  div_last,
    input  logic                  mend,
    input  logic                  strobe_edge,
    output logic                  ready,
    output psram_pkg::bus_phase_t phase,
    output logic                  clk_run,
    output logic                  rd_en,
    output logic                  wr_valid,
    output logic                  psram_ce,
    output logic                  done,
    output logic                  init_done
);
    import psram_pkg::*;

    localparam int INIT_W = $clog2(`PSRAM_INIT_CYCLES + 1);
    localparam int REC_W  = $clog2(`PSRAM_CPH_CYCLES + 1);
    localparam int CNT_W  = $clog2(`PSRAM_MAX_BURST + 1);
    localparam int LEN_W  = $bits(req.burst_len);

    psram_state_e      state_q;
    psram_state_e      state_d;
    psram_req_t        req_q;
    logic [INIT_W-1:0] init_cnt;
    logic [REC_W-1:0]  rec_cnt;
    logic [CNT_W-1:0]  data_cnt;
    logic [LEN_W-1:0]  data_cnt_w;
    logic [2:0]        lat_cnt;
    logic [1:0]        beat_idx;
    logic [1:0]        mr_index;
    logic              cfg_started;
    logic              accept;
    logic              rec_end;

    assign accept     = (state_q == READY) && req_valid;
    assign rec_end    = (state_q == RECOVER) && (rec_cnt == REC_W'(`PSRAM_CPH_CYCLES - 1));
    assign data_cnt_w = {{(LEN_W - CNT_W){1'b0}}, data_cnt};

    assign ready    = (state_q == READY);
    assign rd_en    = (state_q == READ);
    assign clk_run  = !(state_q inside {POWER_UP, READY, DONE, RECOVER});
    assign wr_valid = (state_q == WRITE) && mend && (data_cnt_w < req_q.burst_len);

    assign phase.state    = state_q;
    assign phase.mr_index = mr_index;
    assign phase.beat_idx = beat_idx;
    assign phase.req      = req_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            POWER_UP: begin
                if (init_cnt == INIT_W'(`PSRAM_INIT_CYCLES - 1)) begin
                    state_d = RESET_CMD;
                end
            end
            RESET_CMD: begin
                if (div_last) begin
                    state_d = RESET_WAIT;
                end
            end
            // three psram clocks after the global reset
            RESET_WAIT: begin
                if (div_last && beat_idx == 2'd2) begin
                    state_d = DONE;
                end
            end
            // command, don't care, register address, value
            MR_WRITE: begin
                if (div_last && beat_idx == 2'd3) begin
                    state_d = DONE;
                end
            end
            READY: begin
                if (req_valid) begin
                    state_d = COMMAND;
                end
            end
            COMMAND: begin
                if (div_last) begin
                    state_d = ADDRESS;
                end
            end
            ADDRESS: begin
                if (div_last && beat_idx == 2'd1) begin
                    state_d = LATENCY;
                end
            end
            LATENCY: begin
                if (div_last && lat_cnt == 3'(`PSRAM_LATENCY - 1)) begin
                    state_d = req_q.write ? WRITE : READ;
                end
            end
            WRITE: begin
                if (mend && data_cnt_w == req_q.burst_len) begin
                    state_d = DONE;
                end
            end
            READ: begin
                if (data_cnt_w == req_q.burst_len) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = RECOVER;
            end
            RECOVER: begin
                if (rec_end) begin
                    if (init_done || (cfg_started && mr_index == 2'd2)) begin
                        state_d = READY;
                    end else begin
                        state_d = MR_WRITE;
                    end
                end
            end
            default: begin
                state_d = POWER_UP;
            end
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            state_q  <= POWER_UP;
            psram_ce <= 1'b1;
            done     <= 1'b0;
        end else begin
            state_q  <= state_d;
            // ce trails the state by one cycle so the last clock edge lands inside it
            psram_ce <= (state_q inside {POWER_UP, READY, RECOVER});
            done     <= rec_end;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            init_cnt <= '0;
            rec_cnt  <= '0;
            lat_cnt  <= '0;
            beat_idx <= '0;
        end else begin
            if (state_q == POWER_UP) begin
                init_cnt <= init_cnt + 1'b1;
            end
            rec_cnt <= (state_q == RECOVER) ? rec_cnt + 1'b1 : '0;
            if (state_q != LATENCY) begin
                lat_cnt <= '0;
            end else if (div_last) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
            if (!(state_q inside {RESET_WAIT, MR_WRITE, ADDRESS})) begin
                beat_idx <= '0;
            end else if (div_last) begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    // write beats pulled on mend, read beats counted on device strobe
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            data_cnt <= '0;
        end else if (state_q == WRITE) begin
            if (wr_valid) begin
                data_cnt <= data_cnt + 1'b1;
            end
        end else if (state_q == READ) begin
            if (strobe_edge) begin
                data_cnt <= data_cnt + 1'b1;
            end
        end else begin
            data_cnt <= '0;
        end
    end

    // init steps: reset, then MR0, MR4, MR8
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            cfg_started <= 1'b0;
            mr_index    <= 2'd0;
            init_done   <= 1'b0;
        end else if (rec_end && !init_done) begin
            if (!cfg_started) begin
                cfg_started <= 1'b1;
            end else if (mr_index == 2'd2) begin
                init_done <= 1'b1;
            end else begin
                mr_index <= mr_index + 1'b1;
            end
        end
    end

    a_no_early_req: assert property (@(posedge sys_clk) disable iff (!sys_rst)
        accept |-> init_done);

    a_data_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst)
        (state_q inside {WRITE, READ}) |-> data_cnt_w <= req_q.burst_len);

endmodule

// ==== source/psram_bus_encoder.sv ====
`timescale 1ns/100ps
`include "psram_settings.svh"

module psram_bus_encoder (
    input  logic                   sys_clk,
    input  logic                   sys_rst,
    input  psram_pkg::bus_phase_t  phase,
    input  logic                   mend,
    input  psram_pkg::psram_beat_t wr_beat,
    output psram_pkg::psram_pad_t  pad
);
    import psram_pkg::*;

    localparam logic [7:0] CMD_RESET  = 8'hff;
    localparam logic [7:0] CMD_MR_WR  = 8'hc0;
    localparam logic [7:0] CMD_READ   = 8'h20;
    localparam logic [7:0] CMD_WRITE  = 8'ha0;

    localparam logic [7:0] MR0_VALUE = {3'b000, `PSRAM_LATENCY_CODE, 2'b01};
    localparam logic [7:0] MR4_VALUE = {`PSRAM_LATENCY_CODE, 5'b00000};
    localparam logic [7:0] MR8_VALUE = {1'b0, `PSRAM_X16, 2'b00, 1'b0, `PSRAM_HYBRID_WRAP,
                                        `PSRAM_BL_CODE};

    logic       half;
    logic       bus_idle;
    logic [7:0] mr_addr;
    logic [7:0] mr_value;
    logic [7:0] addr_byte;
    psram_pad_t pad_d;

    assign bus_idle = phase.state inside {POWER_UP, READY, RECOVER};

    // second mend of each psram clock
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            half <= 1'b0;
        end else if (bus_idle) begin
            half <= 1'b0;
        end else if (mend) begin
            half <= ~half;
        end
    end

    always_comb begin
        case (phase.mr_index)
            2'd0: begin
                mr_addr  = 8'h00;
                mr_value = MR0_VALUE;
            end
            2'd1: begin
                mr_addr  = 8'h04;
                mr_value = MR4_VALUE;
            end
            default: begin
                mr_addr  = 8'h08;
                mr_value = MR8_VALUE;
            end
        endcase
    end

    // address goes out high byte first, one byte per clock edge
    always_comb begin
        case ({phase.beat_idx[0], half})
            2'b00:   addr_byte = phase.req.addr[31:24];
            2'b01:   addr_byte = phase.req.addr[23:16];
            2'b10:   addr_byte = phase.req.addr[15:8];
            default: addr_byte = phase.req.addr[7:0];
        endcase
    end

    always_comb begin
        pad_d = '0;
        case (phase.state)
            RESET_CMD: begin
                pad_d.dq = {8'h00, CMD_RESET};
            end
            MR_WRITE: begin
                case (phase.beat_idx)
                    2'd0:    pad_d.dq = {8'h00, CMD_MR_WR};
                    2'd2:    pad_d.dq = {8'h00, mr_addr};
                    2'd3:    pad_d.dq = {8'h00, mr_value};
                    default: pad_d.dq = 16'h0000;
                endcase
            end
            COMMAND: begin
                pad_d.dq = {8'h00, phase.req.write ? CMD_WRITE : CMD_READ};
            end
            ADDRESS: begin
                pad_d.dq = {8'h00, addr_byte};
            end
            WRITE: begin
                pad_d.dq = wr_beat.data;
                pad_d.dm = wr_beat.mask;
            end
            default: begin
                pad_d = '0;
            end
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            pad <= '0;
        end else if (mend) begin
            pad <= pad_d;
        end else if (bus_idle) begin
            pad <= '0;
        end
    end

endmodule

// ==== source/psram_read_capture.sv ====
`timescale 1ns/100ps

module psram_read_capture (
    input  logic        sys_clk,
    input  logic        sys_rst,
    input  logic        rd_en,
    input  logic [15:0] dq_in,
    input  logic        dm_in,
    output logic        strobe_edge,
    output logic        rd_valid,
    output logic [15:0] rd_data
);
    logic        dm_meta;
    logic        dm_prev;
    logic [15:0] dq_meta;

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            dm_meta  <= 1'b0;
            dm_prev  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            dm_meta  <= dm_in;
            dm_prev  <= dm_meta;
            rd_valid <= strobe_edge;
        end
    end

    // both strobe edges carry a beat
    assign strobe_edge = rd_en && (dm_meta ^ dm_prev);

    // dq sampled alongside the strobe
    always_ff @(posedge sys_clk) begin
        dq_meta <= dq_in;
        if (strobe_edge) begin
            rd_data <= dq_meta;
        end
    end

endmodule

// ==== source/psram_ctrl_top.sv ====
`timescale 1ns/100ps

module psram_ctrl_top (
    input  logic                   sys_clk,
    input  logic                   sys_rst,
    input  logic                   req_valid,
    input  psram_pkg::psram_req_t  req,
    output logic                   ready,
    input  psram_pkg::psram_beat_t wr_beat,
    output logic                   wr_valid,
    output logic                   rd_valid,
    output logic [15:0]            rd_data,
    output logic                   done,
    output logic                   init_done,
    output logic                   psram_clk,
    output logic                   psram_ce,
    inout  wire  [15:0]            psram_dq,
    inout  wire  [1:0]             psram_dm
);
    import psram_pkg::*;

    bus_phase_t phase;
    psram_pad_t pad;
    logic       clk_run;
    logic       div_last;
    logic       mend;
    logic       rd_en;
    logic       strobe_edge;

    psram_clk_gen u_clk_gen (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .clk_run   (clk_run),
        .psram_clk (psram_clk),
        .div_last  (div_last),
        .mend      (mend)
    );

    psram_sequencer u_sequencer (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .req_valid   (req_valid),
        .req         (req),
        .div_last    (div_last),
        .mend        (mend),
        .strobe_edge (strobe_edge),
        .ready       (ready),
        .phase       (phase),
        .clk_run     (clk_run),
        .rd_en       (rd_en),
        .wr_valid    (wr_valid),
        .psram_ce    (psram_ce),
        .done        (done),
        .init_done   (init_done)
    );

    psram_bus_encoder u_bus_encoder (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .phase   (phase),
        .mend    (mend),
        .wr_beat (wr_beat),
        .pad     (pad)
    );

    psram_read_capture u_read_capture (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .rd_en       (rd_en),
        .dq_in       (psram_dq),
        .dm_in       (psram_dm[0]),
        .strobe_edge (strobe_edge),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    // device owns dq and dm during read data
    assign psram_dq = rd_en ? 16'hzzzz : pad.dq;
    assign psram_dm = rd_en ? 2'bzz : pad.dm;

endmodule

// ==== sim/tb_clk_rst.sv ====
`timescale 1ns/100ps

module tb_clk_rst (
    output logic sys_clk,
    output logic sys_rst
);
    // 40 ns period
    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    // reset held for three cycles, released on a falling edge
    initial begin
        sys_rst = 1'b0;
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst = 1'b1;
    end

endmodule

// ==== sim/psram_model.sv ====
`timescale 1ns/100ps

module psram_model (
    input  logic       psram_clk,
    input  logic       psram_ce,
    inout  wire [15:0] psram_dq,
    inout  wire [1:0]  psram_dm
);
    // command byte on edges 0-1, address on 2-5, latency on 6-15, data from 16
    localparam int DATA_EDGE = 16;

    logic [15:0] mem [logic [31:0]];
    logic [7:0]  cmd_log [$];
    logic [31:0] addr_log [$];
    logic [7:0]  mr_addr_log [$];
    logic [7:0]  mr_val_log [$];

    int          edge_idx;
    logic [7:0]  cmd;
    logic [31:0] addr;
    logic [7:0]  mr_addr;
    logic        drive;
    logic [15:0] dq_out;
    logic        dm_out;
    logic [31:0] word_addr;
    logic [15:0] word;

    assign psram_dq = drive ? dq_out : 16'hzzzz;
    assign psram_dm = drive ? {1'b0, dm_out} : 2'bzz;

    // contents of a word never written
    function automatic logic [15:0] fill_word(input logic [31:0] a);
        return a[15:0] ^ {a[23:16], a[31:24]} ^ 16'hc3a5;
    endfunction

    initial begin
        drive    = 1'b0;
        dq_out   = '0;
        dm_out   = 1'b0;
        edge_idx = 0;
        cmd      = '0;
        addr     = '0;
        mr_addr  = '0;
    end

    always @(negedge psram_ce) begin
        edge_idx = 0;
    end

    // ce high ends the transaction and frees the bus
    always @(posedge psram_ce) begin
        drive  = 1'b0;
        dq_out = '0;
        dm_out = 1'b0;
    end

    always @(psram_clk) begin
        if (psram_ce === 1'b0) begin
            if (edge_idx == 0) begin
                cmd = psram_dq[7:0];
                cmd_log.push_back(cmd);
            end
            if (edge_idx >= 2 && edge_idx <= 5) begin
                addr = {addr[23:0], psram_dq[7:0]};
            end
            if (edge_idx == 5 && (cmd == 8'h20 || cmd == 8'ha0)) begin
                addr_log.push_back(addr);
            end
            // register writes: c0, don't care, address, value
            if (cmd == 8'hc0 && edge_idx == 4) begin
                mr_addr = psram_dq[7:0];
            end
            if (cmd == 8'hc0 && edge_idx == 6) begin
                mr_addr_log.push_back(mr_addr);
                mr_val_log.push_back(psram_dq[7:0]);
            end
            if (cmd == 8'ha0 && edge_idx >= DATA_EDGE) begin
                word_addr = addr + 32'(edge_idx - DATA_EDGE);
                word = mem.exists(word_addr) ? mem[word_addr] : fill_word(word_addr);
                if (psram_dm[0] == 1'b0) begin
                    word[7:0] = psram_dq[7:0];
                end
                if (psram_dm[1] == 1'b0) begin
                    word[15:8] = psram_dq[15:8];
                end
                mem[word_addr] = word;
            end
            edge_idx = edge_idx + 1;
            if (cmd == 8'h20 && edge_idx - 1 >= DATA_EDGE - 2) begin
                // takes over the bus with zeros, then one word per edge
                #2;
                drive = 1'b1;
                if (edge_idx - 1 >= DATA_EDGE) begin
                    word_addr = addr + 32'(edge_idx - 1 - DATA_EDGE);
                    dq_out = mem.exists(word_addr) ? mem[word_addr] : fill_word(word_addr);
                    dm_out = ~dm_out;
                end
            end
        end
    end

endmodule

// ==== sim/tb_psram_ctrl.sv ====
`timescale 1ns/100ps
`include "psram_settings.svh"

module tb_psram_ctrl;
    import psram_pkg::*;

    localparam int NROWS   = 9;
    localparam int TIMEOUT = 4000;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [11:0] len;
        logic [1:0]  mask;
    } test_row_t;

    logic        sys_clk;
    logic        sys_rst;
    logic        req_valid;
    psram_req_t  req;
    logic        ready;
    psram_beat_t wr_beat;
    logic        wr_valid;
    logic        rd_valid;
    logic [15:0] rd_data;
    logic        done;
    logic        init_done;
    logic        psram_clk;
    logic        psram_ce;
    wire  [15:0] psram_dq;
    wire  [1:0]  psram_dm;

    test_row_t   rows [0:NROWS-1];
    logic [15:0] ref_mem [logic [31:0]];
    int          seed;
    int          errors;
    int          checks;
    int          n;

    tb_clk_rst u_clk_rst (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst)
    );

    psram_ctrl_top u_dut (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .req_valid (req_valid),
        .req       (req),
        .ready     (ready),
        .wr_beat   (wr_beat),
        .wr_valid  (wr_valid),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .done      (done),
        .init_done (init_done),
        .psram_clk (psram_clk),
        .psram_ce  (psram_ce),
        .psram_dq  (psram_dq),
        .psram_dm  (psram_dm)
    );

    psram_model u_model (
        .psram_clk (psram_clk),
        .psram_ce  (psram_ce),
        .psram_dq  (psram_dq),
        .psram_dm  (psram_dm)
    );

    // unwritten words, same rule as the device model
    function automatic logic [15:0] blank_word(input logic [31:0] a);
        return a[15:0] ^ {a[23:16], a[31:24]} ^ 16'hc3a5;
    endfunction

    function automatic logic [15:0] ref_word(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : blank_word(a);
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic report_summary();
        $display("checks: %0d, errors: %0d", checks, errors);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        report_summary();
        $display("Testbench failed");
        $finish;
    endtask

    task automatic run_row(input test_row_t row);
        logic [15:0] data_q [$];
        logic [15:0] old;
        logic [15:0] exp;
        int          wr_cnt;
        int          rd_cnt;
        int          done_cnt;
        int          beat_i;
        logic        pending;
        wr_cnt   = 0;
        rd_cnt   = 0;
        done_cnt = 0;
        beat_i   = 0;
        pending  = 1'b0;
        if (row.write) begin
            for (int i = 0; i < row.len; i++) begin
                data_q.push_back(16'($random(seed)));
                old = ref_word(row.addr + 32'(i));
                if (!row.mask[0]) old[7:0] = data_q[i][7:0];
                if (!row.mask[1]) old[15:8] = data_q[i][15:8];
                ref_mem[row.addr + 32'(i)] = old;
            end
        end
        n = 0;
        while (!ready) begin
            if (n == TIMEOUT) abort_on_timeout("ready");
            @(negedge sys_clk);
            n++;
        end
        check(psram_ce == 1'b1, "chip enable low between transactions");
        req_valid = 1'b1;
        req       = '{write: row.write, addr: row.addr, burst_len: row.len};
        if (row.write) wr_beat = '{data: data_q[0], mask: row.mask};
        else wr_beat = '0;
        @(negedge sys_clk);
        req_valid = 1'b0;
        n = 0;
        while (done_cnt == 0) begin
            // beat taken at the last rising edge, move to the next one
            if (pending) begin
                beat_i++;
                if (beat_i < row.len) wr_beat = '{data: data_q[beat_i], mask: row.mask};
                else wr_beat = '{data: 16'h0000, mask: 2'b11};
            end
            pending = wr_valid;
            if (wr_valid) wr_cnt++;
            if (rd_valid) begin
                exp = ref_word(row.addr + 32'(rd_cnt));
                check(rd_data === exp, $sformatf("read %h at %h, expected %h",
                      rd_data, row.addr + 32'(rd_cnt), exp));
                rd_cnt++;
            end
            if (done) begin
                done_cnt++;
                check(psram_ce == 1'b1, "chip enable low at done");
            end
            if (n == TIMEOUT) abort_on_timeout("done");
            @(negedge sys_clk);
            n++;
        end
        repeat (`PSRAM_CPH_CYCLES + 4) begin
            if (done) done_cnt++;
            @(negedge sys_clk);
        end
        check(done_cnt == 1, $sformatf("%0d done pulses", done_cnt));
        check(wr_cnt == (row.write ? int'(row.len) : 0), $sformatf("%0d write pulses", wr_cnt));
        check(rd_cnt == (row.write ? 0 : int'(row.len)), $sformatf("%0d read pulses", rd_cnt));
    endtask

    initial begin
        req_valid = 1'b0;
        req       = '0;
        wr_beat   = '0;
        seed      = 4144;
        errors    = 0;
        checks    = 0;
        // op, address, beats, mask
        rows[0] = '{1'b1, 32'h0000_0100, 12'd8,  2'b00};
        rows[1] = '{1'b0, 32'h0000_0100, 12'd8,  2'b00};
        rows[2] = '{1'b1, 32'h0000_0104, 12'd4,  2'b01};
        rows[3] = '{1'b0, 32'h0000_0100, 12'd8,  2'b00};
        rows[4] = '{1'b1, 32'h0012_0200, 12'd5,  2'b10};
        rows[5] = '{1'b0, 32'h0012_0200, 12'd5,  2'b00};
        rows[6] = '{1'b0, 32'h0000_1000, 12'd3,  2'b00};
        rows[7] = '{1'b1, 32'hab00_2000, 12'd16, 2'b00};
        rows[8] = '{1'b0, 32'hab00_2000, 12'd16, 2'b00};
        n = 0;
        while (!sys_rst) begin
            if (n == TIMEOUT) abort_on_timeout("reset release");
            @(negedge sys_clk);
            n++;
        end
        @(negedge sys_clk);
        check(psram_ce == 1'b1 && ready == 1'b0, "bus not idle after reset");
        check(init_done == 1'b0 && done == 1'b0, "init_done or done high after reset");
        check(psram_clk == 1'b0 && wr_valid == 1'b0 && rd_valid == 1'b0,
              "psram clock or data strobes active after reset");
        n = 0;
        while (!init_done) begin
            if (n == TIMEOUT) abort_on_timeout("init_done");
            @(negedge sys_clk);
            n++;
        end
        check(u_model.cmd_log.size() == 4, "wrong number of init commands");
        check(u_model.mr_addr_log.size() == 3, "wrong number of mode register writes");
        if (u_model.cmd_log.size() == 4 && u_model.mr_addr_log.size() == 3) begin
            check(u_model.cmd_log[0] == 8'hff, "first command not global reset");
            for (int i = 1; i < 4; i++) begin
                check(u_model.cmd_log[i] == 8'hc0, "init command not register write");
            end
            check(u_model.mr_addr_log[0] == 8'h00 && u_model.mr_addr_log[1] == 8'h04 &&
                  u_model.mr_addr_log[2] == 8'h08, "mode register order");
            // mode register fields one by one
            check(u_model.mr_val_log[0][7:5] == 3'b000 &&
                  u_model.mr_val_log[0][4:2] == `PSRAM_LATENCY_CODE &&
                  u_model.mr_val_log[0][1:0] == 2'b01, "MR0 value");
            check(u_model.mr_val_log[1][7:5] == `PSRAM_LATENCY_CODE &&
                  u_model.mr_val_log[1][4:0] == 5'd0, "MR4 value");
            check(u_model.mr_val_log[2][7] == 1'b0 &&
                  u_model.mr_val_log[2][6] == `PSRAM_X16 &&
                  u_model.mr_val_log[2][5:3] == 3'b000 &&
                  u_model.mr_val_log[2][2] == `PSRAM_HYBRID_WRAP &&
                  u_model.mr_val_log[2][1:0] == `PSRAM_BL_CODE, "MR8 value");
        end
        for (int r = 0; r < NROWS; r++) begin
            run_row(rows[r]);
        end
        // command and address seen on the bus per row
        check(u_model.addr_log.size() == NROWS, "wrong number of bus transactions");
        check(u_model.cmd_log.size() == NROWS + 4, "wrong number of bus commands");
        if (u_model.addr_log.size() == NROWS && u_model.cmd_log.size() == NROWS + 4) begin
            for (int r = 0; r < NROWS; r++) begin
                check(u_model.cmd_log[r + 4] == (rows[r].write ? 8'ha0 : 8'h20),
                      $sformatf("row %0d command %h", r, u_model.cmd_log[r + 4]));
                check(u_model.addr_log[r] == rows[r].addr,
                      $sformatf("row %0d address %h", r, u_model.addr_log[r]));
            end
        end
        report_summary();
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+source
source/psram_pkg.sv
source/psram_clk_gen.sv
source/psram_sequencer.sv
source/psram_bus_encoder.sv
source/psram_read_capture.sv
source/psram_ctrl_top.sv
sim/tb_clk_rst.sv
sim/psram_model.sv
sim/tb_psram_ctrl.sv

// ==== Bender.yml ====
package:
  name: psram_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/psram_pkg.sv
      - source/psram_clk_gen.sv
      - source/psram_sequencer.sv
      - source/psram_bus_encoder.sv
      - source/psram_read_capture.sv
      - source/psram_ctrl_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_clk_rst.sv
      - sim/psram_model.sv
      - sim/tb_psram_ctrl.sv
